// File: build.f
+incdir+common
common/trellisPkg.sv
matchedFilter/matchedFilter.sv
logic/bitDecision.sv
logic/dacSelect.sv
logic/trellisFront.sv
verification/trellisFront_assertions.sv
verification/trellisFrontTb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the trellis front testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -j 0 \
  -f build.f --top-module trellisFrontTb \
  --Mdir "$buildDir" -o trellisFrontSim
status=$?
if [ "$status" -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

"./$buildDir/trellisFrontSim" > "$logFile" 2>&1
status=$?
cat "$logFile"

if grep -q "Testbench failed" "$logFile"; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

// File: verification/trellisFrontTb.sv
`include "trellis_defines.svh"
`default_nettype none

module trellisFrontTb;
  timeunit 1ns;
  timeprecision 100ps;

  // ----------------------------------------------------------------------
  // run length and limits
  // ----------------------------------------------------------------------
  localparam int Symbols = 300;
  localparam int ResetCycles = 4;
  localparam int MaxSymbolCycles = 8;
  localparam int ClkPeriod = 20;
  // worst case symbol spacing plus reset and drain
  localparam int TimeoutNs = (Symbols * MaxSymbolCycles + ResetCycles + 40) * ClkPeriod;
  localparam logic [31:0] Seed = 32'hbce8bed0;
  localparam longint MaxSample = (longint'(1) <<< (`SAMPLE_BITS - 1)) - 1;
  localparam longint MinSample = -(longint'(1) <<< (`SAMPLE_BITS - 1));

  typedef logic signed [63:0] wideType;
  // filter results due in a given cycle
  typedef struct packed {
    int due;
    trellisPkg::sampleType f0I;
    trellisPkg::sampleType f1I;
  } filtEntry;
  typedef struct packed {
    int due;
    logic bitValue;
  } decEntry;

  logic clk, reset, symEn, sym2xEn;
  trellisPkg::sampleType iIn, qIn;
  logic [`DAC_SEL_BITS-1:0] dacSel [`DAC_CHANNELS];
  logic [`DAC_SEL_BITS-1:0] selNext [`DAC_CHANNELS];
  logic decision, symEnOut, sym2xEnOut;
  logic dacSync [`DAC_CHANNELS];
  trellisPkg::sampleType dacData [`DAC_CHANNELS];

  trellisFront i_dut (
    .clk(clk), .reset(reset), .symEn(symEn), .sym2xEn(sym2xEn),
    .iIn(iIn), .qIn(qIn),
    .dac0Select(dacSel[0]), .dac1Select(dacSel[1]), .dac2Select(dacSel[2]),
    .decision(decision), .symEnOut(symEnOut), .sym2xEnOut(sym2xEnOut),
    .dac0Sync(dacSync[0]), .dac1Sync(dacSync[1]), .dac2Sync(dacSync[2]),
    .dac0Data(dacData[0]), .dac1Data(dacData[1]), .dac2Data(dacData[2])
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // reference model state for the current cycle
  // ----------------------------------------------------------------------
  int cycle;
  int errors;
  int strobes;
  filtEntry filtQueue[$];
  decEntry decQueue[$];
  trellisPkg::sampleType hold0I, hold0Q;
  trellisPkg::sampleType expF0I, expF1I;
  logic expFiltValid, expDecision, expSymEnOut, expSym2x, lastSymEnOut;
  trellisPkg::sampleType expData [`DAC_CHANNELS];
  logic expSync [`DAC_CHANNELS];

  task automatic compareValue(input string what, input wideType actual, input wideType expected);
    if (actual !== expected) begin
      errors++;
      $display("Fail at %t: %s is %0d, expected %0d", $time, what, actual, expected);
      $display("Testbench failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // arithmetic shift by the coefficient fraction then clamp
  function automatic trellisPkg::sampleType scaleClamp(input longint sum);
    longint scaled;
    scaled = sum >>> `COEF_FRAC;
    if (scaled > MaxSample) begin
      return trellisPkg::sampleType'(MaxSample);
    end
    if (scaled < MinSample) begin
      return trellisPkg::sampleType'(MinSample);
    end
    return trellisPkg::sampleType'(scaled);
  endfunction

  // x0 * c0 + x1 * c1 in complex arithmetic
  task automatic correlate(input trellisPkg::sampleType x0I, x0Q, x1I, x1Q,
                           input trellisPkg::sampleType c0Re, c0Im, c1Re, c1Im,
                           output trellisPkg::sampleType re, im);
    longint sumRe, sumIm;
    sumRe = longint'(x0I) * longint'(c0Re) - longint'(x0Q) * longint'(c0Im)
          + longint'(x1I) * longint'(c1Re) - longint'(x1Q) * longint'(c1Im);
    sumIm = longint'(x0I) * longint'(c0Im) + longint'(x0Q) * longint'(c0Re)
          + longint'(x1I) * longint'(c1Im) + longint'(x1Q) * longint'(c1Re);
    re = scaleClamp(sumRe);
    im = scaleClamp(sumIm);
  endtask

  // i^2 + q^2 on the top MAG_BITS only
  function automatic longint energy(input trellisPkg::sampleType i, q);
    longint iTop, qTop;
    iTop = longint'(i) >>> (`SAMPLE_BITS - `MAG_BITS);
    qTop = longint'(q) >>> (`SAMPLE_BITS - `MAG_BITS);
    return iTop * iTop + qTop * qTop;
  endfunction

  task automatic clearModel();
    filtQueue.delete();
    decQueue.delete();
    {expF0I, expF1I} = '0;
    {expFiltValid, expDecision, expSymEnOut, expSym2x, lastSymEnOut} = '0;
    for (int ch = 0; ch < `DAC_CHANNELS; ch++) begin
      expData[ch] = '0;
      expSync[ch] = 1'b0;
    end
  endtask

  // step the model from this cycle's inputs to the next cycle's outputs
  task automatic advanceModel();
    trellisPkg::sampleType r0I, r0Q, r1I, r1Q;
    filtEntry fe;
    decEntry de;
    if (reset) begin
      clearModel();
    end else begin
      // monitors register this cycle's source and strobe
      for (int ch = 0; ch < `DAC_CHANNELS; ch++) begin
        case (dacSel[ch])
          `DAC_TRELLIS_I: begin
            expData[ch] = iIn;
            expSync[ch] = sym2xEn;
          end
          `DAC_TRELLIS_Q: begin
            expData[ch] = qIn;
            expSync[ch] = sym2xEn;
          end
          `DAC_TRELLIS_F1: begin
            expData[ch] = expF1I;
            expSync[ch] = expFiltValid;
          end
          default: begin
            expData[ch] = expF0I;
            expSync[ch] = expFiltValid;
          end
        endcase
      end
      // 2x strobe from the last two decision strobes
      expSym2x = expSymEnOut | lastSymEnOut;
      lastSymEnOut = expSymEnOut;
      if (sym2xEn && !symEn) begin
        hold0I = iIn;
        hold0Q = qIn;
      end
      if (sym2xEn && symEn) begin
        correlate(hold0I, hold0Q, iIn, qIn, `F0_C0_RE, `F0_C0_IM, `F0_C1_RE, `F0_C1_IM,
                  r0I, r0Q);
        correlate(hold0I, hold0Q, iIn, qIn, `F1_C0_RE, `F1_C0_IM, `F1_C1_RE, `F1_C1_IM,
                  r1I, r1Q);
        fe = '{cycle + 2, r0I, r1I};
        filtQueue.push_back(fe);
        de = '{cycle + 4, energy(r1I, r1Q) > energy(r0I, r0Q)};
        decQueue.push_back(de);
      end
      expFiltValid = 1'b0;
      if (filtQueue.size() > 0 && filtQueue[0].due == cycle + 1) begin
        fe = filtQueue.pop_front();
        {expF0I, expF1I} = {fe.f0I, fe.f1I};
        expFiltValid = 1'b1;
      end
      expSymEnOut = 1'b0;
      if (decQueue.size() > 0 && decQueue[0].due == cycle + 1) begin
        de = decQueue.pop_front();
        expDecision = de.bitValue;
        expSymEnOut = 1'b1;
      end
    end
  endtask

  task automatic checkOutputs();
    compareValue("symEnOut", wideType'(symEnOut), wideType'(expSymEnOut));
    compareValue("sym2xEnOut", wideType'(sym2xEnOut), wideType'(expSym2x));
    compareValue("decision", wideType'(decision), wideType'(expDecision));
    for (int ch = 0; ch < `DAC_CHANNELS; ch++) begin
      compareValue($sformatf("dac%0dData", ch), wideType'(dacData[ch]), wideType'(expData[ch]));
      compareValue($sformatf("dac%0dSync", ch), wideType'(dacSync[ch]), wideType'(expSync[ch]));
    end
    if (symEnOut === 1'b1) begin
      strobes++;
    end
  endtask

  // ----------------------------------------------------------------------
  // stimulus one cycle per call on the falling edge
  // ----------------------------------------------------------------------
  task automatic driveCycle(input logic rst, input logic s2x, input logic s,
                            input trellisPkg::sampleType i, input trellisPkg::sampleType q);
    @(negedge clk);
    checkOutputs();
    reset = rst;
    sym2xEn = s2x;
    symEn = s;
    iIn = i;
    qIn = q;
    for (int ch = 0; ch < `DAC_CHANNELS; ch++) begin
      dacSel[ch] = selNext[ch];
    end
    advanceModel();
    cycle++;
  endtask

  function automatic trellisPkg::sampleType randomSample();
    int unsigned pick;
    pick = $urandom_range(0, 7);
    // rails now and then push the filters into saturation
    if (pick == 0) begin
      return trellisPkg::sampleType'(MaxSample);
    end
    if (pick == 1) begin
      return trellisPkg::sampleType'(MinSample);
    end
    return trellisPkg::sampleType'($urandom());
  endfunction

  function automatic logic [`DAC_SEL_BITS-1:0] randomSelect();
    int unsigned pick;
    pick = $urandom_range(0, 4);
    // unused code lands on the f0 monitor
    if (pick == 4) begin
      return 4'd7;
    end
    return pick[`DAC_SEL_BITS-1:0];
  endfunction

  task automatic sendSymbol();
    int gapA, gapB;
    gapA = $urandom_range(0, 2);
    gapB = $urandom_range(0, 2);
    // sample 1 strobes stay 3+ cycles apart
    if (gapA + gapB == 0) begin
      gapA = 1;
    end
    for (int ch = 0; ch < `DAC_CHANNELS; ch++) begin
      selNext[ch] = randomSelect();
    end
    repeat (gapA) driveCycle(1'b0, 1'b0, 1'b0, randomSample(), randomSample());
    driveCycle(1'b0, 1'b1, 1'b0, randomSample(), randomSample());
    repeat (gapB) driveCycle(1'b0, 1'b0, 1'b0, randomSample(), randomSample());
    driveCycle(1'b0, 1'b1, 1'b1, randomSample(), randomSample());
  endtask

  initial begin
    #(TimeoutNs);
    $display("Timeout: the run did not finish within %t", $time);
    $display("Testbench failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(Seed));
    errors = 0;
    strobes = 0;
    cycle = 0;
    reset = 1'b1;
    symEn = 1'b0;
    sym2xEn = 1'b0;
    iIn = '0;
    qIn = '0;
    for (int ch = 0; ch < `DAC_CHANNELS; ch++) begin
      dacSel[ch] = `DAC_TRELLIS_I;
      selNext[ch] = `DAC_TRELLIS_I;
    end
    clearModel();
    // first rising edge already sees reset high
    repeat (ResetCycles - 1) driveCycle(1'b1, 1'b0, 1'b0, '0, '0);
    for (int s = 0; s < Symbols; s++) begin
      sendSymbol();
    end
    // drain the pipeline
    repeat (10) driveCycle(1'b0, 1'b0, 1'b0, randomSample(), randomSample());
    compareValue("decision strobes", wideType'(strobes), wideType'(Symbols));
    compareValue("model entries left", wideType'(filtQueue.size() + decQueue.size()),
                 wideType'(0));
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/trellisFront_assertions.sv
`default_nettype none

module trellisFrontAssertions (
  input wire logic clk,
  input wire logic reset,
  input wire logic symEnOut,
  input wire logic sym2xEnOut,
  input wire logic dac0Sync,
  input wire logic dac1Sync,
  input wire logic dac2Sync
);
  timeunit 1ns;
  timeprecision 100ps;

  wire logic anyStrobe = symEnOut || sym2xEnOut || dac0Sync || dac1Sync || dac2Sync;

  // ----------------------------------------------------------------------
  // 2x strobe follows each decision for two cycles
  // ----------------------------------------------------------------------
  stretchFirst: assert property (@(posedge clk) disable iff (reset)
    symEnOut |=> sym2xEnOut)
    else $error("sym2xEnOut low one cycle after symEnOut");

  stretchSecond: assert property (@(posedge clk) disable iff (reset)
    $past(symEnOut) |=> sym2xEnOut)
    else $error("sym2xEnOut low two cycles after symEnOut");

  // decisions 3+ cycles apart
  strobeSpacing: assert property (@(posedge clk) disable iff (reset)
    symEnOut |-> !$past(symEnOut) && !$past(symEnOut, 2))
    else $error("symEnOut pulses closer than 3 cycles");

  // sync reset, strobes clear one edge after reset is seen
  resetQuiet: assert property (@(posedge clk) $past(reset) |-> !anyStrobe)
    else $error("strobe high during reset");

endmodule

bind trellisFront trellisFrontAssertions assertions (
  .clk(clk), .reset(reset), .symEnOut(symEnOut), .sym2xEnOut(sym2xEnOut),
  .dac0Sync(dac0Sync), .dac1Sync(dac1Sync), .dac2Sync(dac2Sync)
);

`default_nettype wire

// File: logic/trellisFront.sv
`include "trellis_defines.svh"
`default_nettype none

module trellisFront (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire logic                     symEn,
  input  wire logic                     sym2xEn,
  input  wire trellisPkg::sampleType    iIn,
  input  wire trellisPkg::sampleType    qIn,
  input  wire logic [`DAC_SEL_BITS-1:0] dac0Select,
  input  wire logic [`DAC_SEL_BITS-1:0] dac1Select,
  input  wire logic [`DAC_SEL_BITS-1:0] dac2Select,
  output logic                          decision,
  output logic                          symEnOut,
  output logic                          sym2xEnOut,
  output logic                          dac0Sync,
  output logic                          dac1Sync,
  output logic                          dac2Sync,
  output trellisPkg::sampleType         dac0Data,
  output trellisPkg::sampleType         dac1Data,
  output trellisPkg::sampleType         dac2Data
);

  // ----------------------------------------------------------------------
  // matched filters, one per reference waveform
  // ----------------------------------------------------------------------
  trellisPkg::sampleType f0I, f0Q, f1I, f1Q;
  logic filtValid;

  matchedFilter #(`F0_C0_RE, `F0_C0_IM, `F0_C1_RE, `F0_C1_IM) f0 (
    .clk(clk), .reset(reset), .symEn(symEn), .sym2xEn(sym2xEn),
    .iIn(iIn), .qIn(qIn),
    .filtI(f0I), .filtQ(f0Q), .filtValid(filtValid)
  );

  // same timing as f0, its strobe is not needed
  matchedFilter #(`F1_C0_RE, `F1_C0_IM, `F1_C1_RE, `F1_C1_IM) f1 (
    .clk(clk), .reset(reset), .symEn(symEn), .sym2xEn(sym2xEn),
    .iIn(iIn), .qIn(qIn),
    .filtI(f1I), .filtQ(f1Q), .filtValid()
  );

  // ----------------------------------------------------------------------
  // noncoherent bit decision
  // ----------------------------------------------------------------------
  bitDecision bitDecision (
    .clk(clk), .reset(reset), .filtValid(filtValid),
    .f0I(f0I), .f0Q(f0Q), .f1I(f1I), .f1Q(f1Q),
    .decision(decision), .symEnOut(symEnOut), .sym2xEnOut(sym2xEnOut)
  );

  // ----------------------------------------------------------------------
  // dac monitors
  // ----------------------------------------------------------------------
  dacSelect dacSelect (
    .clk(clk), .reset(reset), .sym2xEn(sym2xEn), .filtValid(filtValid),
    .iIn(iIn), .qIn(qIn), .f0I(f0I), .f1I(f1I),
    .dac0Select(dac0Select), .dac1Select(dac1Select), .dac2Select(dac2Select),
    .dac0Data(dac0Data), .dac1Data(dac1Data), .dac2Data(dac2Data),
    .dac0Sync(dac0Sync), .dac1Sync(dac1Sync), .dac2Sync(dac2Sync)
  );

endmodule

`default_nettype wire

// File: logic/dacSelect.sv
`include "trellis_defines.svh"
`default_nettype none

module dacSelect (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire logic                     sym2xEn,
  input  wire logic                     filtValid,
  input  wire trellisPkg::sampleType    iIn,
  input  wire trellisPkg::sampleType    qIn,
  input  wire trellisPkg::sampleType    f0I,
  input  wire trellisPkg::sampleType    f1I,
  input  wire logic [`DAC_SEL_BITS-1:0] dac0Select,
  input  wire logic [`DAC_SEL_BITS-1:0] dac1Select,
  input  wire logic [`DAC_SEL_BITS-1:0] dac2Select,
  output trellisPkg::sampleType         dac0Data,
  output trellisPkg::sampleType         dac1Data,
  output trellisPkg::sampleType         dac2Data,
  output logic                          dac0Sync,
  output logic                          dac1Sync,
  output logic                          dac2Sync
);

  logic [`DAC_SEL_BITS-1:0] sel [`DAC_CHANNELS];
  trellisPkg::sampleType dataReg [`DAC_CHANNELS];
  logic syncReg [`DAC_CHANNELS];

  assign sel[0] = dac0Select;
  assign sel[1] = dac1Select;
  assign sel[2] = dac2Select;

  // ----------------------------------------------------------------------
  // one registered mux per channel
  // ----------------------------------------------------------------------
  for (genvar ch = 0; ch < `DAC_CHANNELS; ch++) begin : gChannel
    always_ff @(posedge clk) begin
      if (reset) begin
        dataReg[ch] <= '0;
        syncReg[ch] <= 1'b0;
      end else begin
        case (sel[ch])
          `DAC_TRELLIS_I: begin
            dataReg[ch] <= iIn;
            syncReg[ch] <= sym2xEn;
          end
          `DAC_TRELLIS_Q: begin
            dataReg[ch] <= qIn;
            syncReg[ch] <= sym2xEn;
          end
          `DAC_TRELLIS_F1: begin
            dataReg[ch] <= f1I;
            syncReg[ch] <= filtValid;
          end
          // f0 output, also for unknown codes
          default: begin
            dataReg[ch] <= f0I;
            syncReg[ch] <= filtValid;
          end
        endcase
      end
    end
  end

  assign dac0Data = dataReg[0];
  assign dac1Data = dataReg[1];
  assign dac2Data = dataReg[2];
  assign dac0Sync = syncReg[0];
  assign dac1Sync = syncReg[1];
  assign dac2Sync = syncReg[2];

endmodule

`default_nettype wire

// File: logic/bitDecision.sv
`include "trellis_defines.svh"
`default_nettype none

module bitDecision (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  filtValid,
  input  wire trellisPkg::sampleType f0I,
  input  wire trellisPkg::sampleType f0Q,
  input  wire trellisPkg::sampleType f1I,
  input  wire trellisPkg::sampleType f1Q,
  output logic                       decision,
  output logic                       symEnOut,
  output logic                       sym2xEnOut
);

  // energy of the upper filter bits only
  function automatic trellisPkg::magType energy(input trellisPkg::sampleType i,
                                                input trellisPkg::sampleType q);
    // top bits sign extended to the energy width
    logic signed [2*`MAG_BITS:0] iTop;
    logic signed [2*`MAG_BITS:0] qTop;
    iTop = $signed(i[`SAMPLE_BITS-1:`MAG_SHIFT]);
    qTop = $signed(q[`SAMPLE_BITS-1:`MAG_SHIFT]);
    return trellisPkg::magType'(iTop * iTop) + trellisPkg::magType'(qTop * qTop);
  endfunction

  // ----------------------------------------------------------------------
  // energies one cycle after the filters
  // ----------------------------------------------------------------------
  trellisPkg::magType mag0, mag1;
  logic magValid;

  always_ff @(posedge clk) begin
    if (filtValid) begin
      mag0 <= energy(f0I, f0Q);
      mag1 <= energy(f1I, f1Q);
    end
  end

  // ----------------------------------------------------------------------
  // decision and strobes
  // ----------------------------------------------------------------------
  logic se0;

  always_ff @(posedge clk) begin
    if (reset) begin
      magValid   <= 1'b0;
      decision   <= 1'b0;
      symEnOut   <= 1'b0;
      se0        <= 1'b0;
      sym2xEnOut <= 1'b0;
    end else begin
      magValid <= filtValid;
      symEnOut <= magValid;
      // ties go to zero
      if (magValid) begin
        decision <= mag1 > mag0;
      end
      // stretch 1x strobe to two cycles for the line decoder
      // relies on symbols being 3+ cycles apart
      se0        <= symEnOut;
      sym2xEnOut <= se0 | symEnOut;
    end
  end

endmodule

`default_nettype wire

// File: matchedFilter/matchedFilter.sv
`include "trellis_defines.svh"
`default_nettype none

module matchedFilter #(
  parameter trellisPkg::sampleType c0Re = `F0_C0_RE,
  parameter trellisPkg::sampleType c0Im = `F0_C0_IM,
  parameter trellisPkg::sampleType c1Re = `F0_C1_RE,
  parameter trellisPkg::sampleType c1Im = `F0_C1_IM
) (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  symEn,
  input  wire logic                  sym2xEn,
  input  wire trellisPkg::sampleType iIn,
  input  wire trellisPkg::sampleType qIn,
  output trellisPkg::sampleType      filtI,
  output trellisPkg::sampleType      filtQ,
  output logic                       filtValid
);

  localparam int ProdBits = $bits(trellisPkg::productType);

  // clamp the shifted sum into the sample range
  function automatic trellisPkg::sampleType saturate(input trellisPkg::productType v);
    logic [ProdBits-`SAMPLE_BITS:0] top;
    top = v[ProdBits-1:`SAMPLE_BITS-1];
    if (&top || ~|top) begin
      return v[`SAMPLE_BITS-1:0];
    end
    // out of range, pick the rail from the sign
    if (v[ProdBits-1]) begin
      return {1'b1, {(`SAMPLE_BITS-1){1'b0}}};
    end
    return {1'b0, {(`SAMPLE_BITS-1){1'b1}}};
  endfunction

  // ----------------------------------------------------------------------
  // sample 0 hold
  // ----------------------------------------------------------------------
  trellisPkg::sampleType x0I, x0Q;
  wire logic firstSample = sym2xEn && !symEn;
  wire logic secondSample = sym2xEn && symEn;

  always_ff @(posedge clk) begin
    if (firstSample) begin
      x0I <= iIn;
      x0Q <= qIn;
    end
  end

  // ----------------------------------------------------------------------
  // stage 1, products on sample 1
  // ----------------------------------------------------------------------
  // order per part: x0I, x0Q, x1I, x1Q terms
  logic signed [2*`SAMPLE_BITS-1:0] prodRe [4];
  logic signed [2*`SAMPLE_BITS-1:0] prodIm [4];
  logic prodValid;

  always_ff @(posedge clk) begin
    if (secondSample) begin
      prodRe[0] <= x0I * c0Re;
      prodRe[1] <= x0Q * c0Im;
      prodRe[2] <= iIn * c1Re;
      prodRe[3] <= qIn * c1Im;
      prodIm[0] <= x0I * c0Im;
      prodIm[1] <= x0Q * c0Re;
      prodIm[2] <= iIn * c1Im;
      prodIm[3] <= qIn * c1Re;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prodValid <= 1'b0;
    end else begin
      prodValid <= secondSample;
    end
  end

  // ----------------------------------------------------------------------
  // stage 2, complex sum, scale and clamp
  // ----------------------------------------------------------------------
  trellisPkg::productType sumRe, sumIm;
  always_comb begin
    // (x0 * c0) + (x1 * c1), complex
    sumRe = prodRe[0] - prodRe[1] + prodRe[2] - prodRe[3];
    sumIm = prodIm[0] + prodIm[1] + prodIm[2] + prodIm[3];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      filtI     <= '0;
      filtQ     <= '0;
      filtValid <= 1'b0;
    end else begin
      filtValid <= prodValid;
      // outputs hold between symbols
      if (prodValid) begin
        filtI <= saturate(sumRe >>> `COEF_FRAC);
        filtQ <= saturate(sumIm >>> `COEF_FRAC);
      end
    end
  end

endmodule

`default_nettype wire

// File: common/trellisPkg.sv
`include "trellis_defines.svh"
`default_nettype none

package trellisPkg;

  // ----------------------------------------------------------------------
  // shared datapath types
  // ----------------------------------------------------------------------

  // baseband sample, coefficient and filter output
  typedef logic signed [`SAMPLE_BITS-1:0] sampleType;

  // sum of four sample x coefficient products, two guard bits
  typedef logic signed [2*`SAMPLE_BITS+1:0] productType;

  // i^2 + q^2 of the truncated filter output, always positive
  typedef logic [2*`MAG_BITS:0] magType;

endpackage

`default_nettype wire

// File: common/trellis_defines.svh
`ifndef TRELLIS_DEFINES_SVH
`define TRELLIS_DEFINES_SVH

// ----------------------------------------------------------------------
// datapath widths
// ----------------------------------------------------------------------
`define SAMPLE_BITS 18
// coefficient fraction bits, also the product sum shift
`define COEF_FRAC 17
// upper filter bits kept for the energy compare
`define MAG_BITS 10
`define MAG_SHIFT (`SAMPLE_BITS - `MAG_BITS)

// ----------------------------------------------------------------------
// matched filter references, sample 0 then sample 1
// ----------------------------------------------------------------------
`define F0_C0_RE 18'h1B48C
`define F0_C0_IM 18'h10B85
`define F0_C1_RE 18'h3D7D4
`define F0_C1_IM 18'h1FE6B
// f1 is the conjugate pair of f0
`define F1_C0_RE 18'h1B48C
`define F1_C0_IM 18'h2F47B
`define F1_C1_RE 18'h3D7D4
`define F1_C1_IM 18'h20195

// ----------------------------------------------------------------------
// dac monitor select codes
// ----------------------------------------------------------------------
`define DAC_SEL_BITS 4
`define DAC_TRELLIS_I 4'd0
`define DAC_TRELLIS_Q 4'd1
`define DAC_TRELLIS_F0 4'd2
`define DAC_TRELLIS_F1 4'd3
`define DAC_CHANNELS 3

`endif
